// File: include/debug_settings.svh
`ifndef DEBUG_SETTINGS_SVH
`define DEBUG_SETTINGS_SVH

`define DBG_DATA_W      8               // UART byte width
`define DBG_WORD_W      32              // Instruction and address width

// Pipeline latch widths as reported by the processor
`define DBG_ID_EX_W     144             // ID/EX latch
`define DBG_EX_MEM_W    32              // EX/MEM latch
`define DBG_MEM_WB_W    40              // MEM/WB latch
`define DBG_CONTROL_W   24              // Control latch

`define DBG_DUMP_BYTES  30              // Bytes sent per dump

`define DBG_HALT_WORD   32'hFFFF_FFFF   // Last word of a program
`define DBG_ADDR_STEP   4               // Byte addresses, one word apart

`endif

// File: hdl/debug_cmd_pkg.sv
`include "debug_settings.svh"

package debug_cmd_pkg;

    // Host command bytes
    typedef enum logic [`DBG_DATA_W-1:0] {
        CMD_LOAD      = 8'h01,  // Start program loading
        CMD_DEBUG     = 8'h02,  // Enter debug mode
        CMD_RUN       = 8'h04,  // Run until end of program
        CMD_STEP      = 8'h08,  // One step then dump
        CMD_END_DEBUG = 8'h10   // Final dump, then leave debug
    } cmd_e;

    // Controller states
    typedef enum logic [2:0] {
        MODE_IDLE,
        MODE_LOAD,
        MODE_DEBUG,
        MODE_RUN,
        MODE_DUMP               // Waiting for the dumper
    } mode_e;

    // Instruction memory write request
    typedef struct packed {
        logic                   valid;  // One-cycle write pulse
        logic [`DBG_WORD_W-1:0] addr;
        logic [`DBG_WORD_W-1:0] word;
    } instr_write_t;

endpackage

// File: hdl/debug_dump_pkg.sv
`include "debug_settings.svh"

package debug_dump_pkg;

    // One byte moment on the UART receive or transmit side
    typedef struct packed {
        logic                   strobe; // One-cycle pulse
        logic [`DBG_DATA_W-1:0] data;
    } uart_byte_t;

    // Pipeline latches as seen by the debug unit
    typedef struct packed {
        logic [`DBG_ID_EX_W-1:0]   id_ex;
        logic [`DBG_EX_MEM_W-1:0]  ex_mem;
        logic [`DBG_MEM_WB_W-1:0]  mem_wb;
        logic [`DBG_CONTROL_W-1:0] control;
    } pipe_snapshot_t;

    // Dump order, one latch after the other
    typedef enum logic [1:0] {
        SEG_ID_EX,
        SEG_EX_MEM,
        SEG_MEM_WB,
        SEG_CONTROL
    } segment_e;

endpackage

// File: hdl/debug_ctrl.sv
`timescale 1ns/1ns

module debug_ctrl (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  debug_dump_pkg::uart_byte_t i_rx,
    input  logic                       i_end,
    input  logic                       i_load_halt,
    input  logic                       i_dump_done,
    output logic                       o_load_en,
    output logic                       o_dump_start,
    output logic                       o_step,
    output logic                       o_start
);

    import debug_cmd_pkg::*;

    mode_e mode;
    mode_e mode_nxt;
    logic  debug_flag;              // Set while debug mode is active
    logic  debug_flag_nxt;
    logic  step_nxt;
    logic  dump_start_nxt;
    cmd_e  cmd;

    assign cmd = cmd_e'(i_rx.data);

    always_comb begin
        mode_nxt       = mode;
        debug_flag_nxt = debug_flag;
        step_nxt       = 1'b0;
        dump_start_nxt = 1'b0;

        case (mode)
            MODE_IDLE: begin
                if (i_rx.strobe) begin
                    case (cmd)
                        CMD_LOAD: mode_nxt = MODE_LOAD;
                        CMD_DEBUG: begin
                            mode_nxt       = MODE_DEBUG;
                            debug_flag_nxt = 1'b1;
                        end
                        CMD_RUN:  mode_nxt = MODE_RUN;
                        default:  mode_nxt = MODE_IDLE;     // Unknown byte
                    endcase
                end
            end

            MODE_LOAD: begin
                if (i_load_halt) begin
                    mode_nxt = MODE_IDLE;                   // Halt word written
                end
            end

            MODE_DEBUG: begin
                if (i_rx.strobe) begin
                    case (cmd)
                        CMD_STEP: begin
                            step_nxt       = 1'b1;
                            dump_start_nxt = 1'b1;
                            mode_nxt       = MODE_DUMP;
                        end
                        CMD_END_DEBUG: begin
                            debug_flag_nxt = 1'b0;          // Return to idle after dump
                            dump_start_nxt = 1'b1;
                            mode_nxt       = MODE_DUMP;
                        end
                        default: mode_nxt = MODE_DEBUG;
                    endcase
                end
            end

            MODE_RUN: begin
                if (i_end) begin
                    dump_start_nxt = 1'b1;
                    mode_nxt       = MODE_DUMP;
                end else begin
                    step_nxt = 1'b1;                        // Free running
                end
            end

            MODE_DUMP: begin
                if (i_dump_done) begin
                    mode_nxt = debug_flag ? MODE_DEBUG : MODE_IDLE;
                end
            end

            default: mode_nxt = MODE_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mode         <= MODE_IDLE;
            debug_flag   <= 1'b0;
            o_step       <= 1'b0;
            o_dump_start <= 1'b0;
            o_start      <= 1'b0;
        end else begin
            mode         <= mode_nxt;
            debug_flag   <= debug_flag_nxt;
            o_step       <= step_nxt;
            o_dump_start <= dump_start_nxt;
            o_start      <= (mode != MODE_IDLE);            // Lags the mode by one cycle
        end
    end

    assign o_load_en = (mode == MODE_LOAD);

endmodule

// File: hdl/instr_loader.sv
`timescale 1ns/1ns
`include "debug_settings.svh"

module instr_loader (
    input  logic                         clk,
    input  logic                         i_rst_n,
    input  debug_dump_pkg::uart_byte_t   i_rx,
    input  logic                         i_load_en,
    output debug_cmd_pkg::instr_write_t  o_instr_wr,
    output logic                         o_load_halt
);

    import debug_cmd_pkg::*;

    localparam int SHIFT_W = `DBG_WORD_W - `DBG_DATA_W;

    logic [1:0]             byte_cnt;       // Bytes of the current word
    logic [SHIFT_W-1:0]     shift_q;        // Upper bytes received so far
    logic [`DBG_WORD_W-1:0] word_nxt;
    logic [`DBG_WORD_W-1:0] addr;           // Address of the next write
    instr_write_t           wr_q;
    logic                   halt_q;

    // Most significant byte arrives first
    assign word_nxt = {shift_q, i_rx.data};

    always_ff @(posedge clk) begin
        if (i_load_en && i_rx.strobe) begin
            shift_q <= word_nxt[SHIFT_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            byte_cnt <= '0;
            addr     <= '0;
            wr_q     <= '0;
            halt_q   <= 1'b0;
        end else begin
            wr_q.valid <= 1'b0;
            halt_q     <= 1'b0;
            if (!i_load_en) begin
                byte_cnt <= '0;
                addr     <= '0;
            end else if (i_rx.strobe) begin
                byte_cnt <= byte_cnt + 2'd1;                // Wraps after the fourth byte
                if (byte_cnt == 2'd3) begin
                    wr_q.valid <= 1'b1;
                    wr_q.addr  <= addr;
                    wr_q.word  <= word_nxt;
                    addr       <= addr + `DBG_WORD_W'(`DBG_ADDR_STEP);
                    halt_q     <= (word_nxt == `DBG_HALT_WORD);
                end
            end
        end
    end

    assign o_instr_wr  = wr_q;
    assign o_load_halt = halt_q;

endmodule

// File: hdl/latch_dumper.sv
`timescale 1ns/1ns
`include "debug_settings.svh"

module latch_dumper (
    input  logic                           clk,
    input  logic                           i_rst_n,
    input  debug_dump_pkg::pipe_snapshot_t i_snapshot,
    input  logic                           i_dump_start,
    input  logic                           i_tx_done,
    output debug_dump_pkg::uart_byte_t     o_tx,
    output logic                           o_dump_done
);

    import debug_dump_pkg::*;

    localparam int IDX_W = $clog2(`DBG_ID_EX_W / `DBG_DATA_W);    // Widest latch
    localparam int CNT_W = $clog2(`DBG_DUMP_BYTES);

    pipe_snapshot_t   snap;
    segment_e         seg;              // Latch of the byte in flight
    segment_e         seg_nxt;
    logic [IDX_W-1:0] idx;              // Byte index within that latch
    logic [IDX_W-1:0] idx_nxt;
    logic [CNT_W-1:0] sent;             // Bytes already started
    logic             busy;
    uart_byte_t       tx_q;
    logic             done_q;

    function automatic logic [IDX_W-1:0] seg_last(input segment_e s);
        case (s)
            SEG_ID_EX:  seg_last = IDX_W'(`DBG_ID_EX_W / `DBG_DATA_W - 1);
            SEG_EX_MEM: seg_last = IDX_W'(`DBG_EX_MEM_W / `DBG_DATA_W - 1);
            SEG_MEM_WB: seg_last = IDX_W'(`DBG_MEM_WB_W / `DBG_DATA_W - 1);
            default:    seg_last = IDX_W'(`DBG_CONTROL_W / `DBG_DATA_W - 1);
        endcase
    endfunction

    // Byte i of a latch, low byte first
    function automatic logic [`DBG_DATA_W-1:0] seg_byte(input pipe_snapshot_t s,
                                                       input segment_e       sg,
                                                       input logic [IDX_W-1:0] i);
        logic [`DBG_ID_EX_W-1:0] bits;
        case (sg)
            SEG_ID_EX:  bits = s.id_ex;
            SEG_EX_MEM: bits = `DBG_ID_EX_W'(s.ex_mem);
            SEG_MEM_WB: bits = `DBG_ID_EX_W'(s.mem_wb);
            default:    bits = `DBG_ID_EX_W'(s.control);
        endcase
        seg_byte = bits[i * `DBG_DATA_W +: `DBG_DATA_W];
    endfunction

    always_comb begin
        if (idx == seg_last(seg)) begin
            seg_nxt = segment_e'(seg + 2'd1);               // On to the next latch
            idx_nxt = '0;
        end else begin
            seg_nxt = seg;
            idx_nxt = idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_dump_start && !busy) begin
            snap <= i_snapshot;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy   <= 1'b0;
            seg    <= SEG_ID_EX;
            idx    <= '0;
            sent   <= '0;
            tx_q   <= '0;
            done_q <= 1'b0;
        end else begin
            tx_q.strobe <= 1'b0;
            done_q      <= 1'b0;
            if (!busy) begin
                if (i_dump_start) begin
                    busy        <= 1'b1;
                    seg         <= SEG_ID_EX;
                    idx         <= '0;
                    sent        <= '0;
                    tx_q.strobe <= 1'b1;                    // First byte straight from input
                    tx_q.data   <= seg_byte(i_snapshot, SEG_ID_EX, '0);
                end
            end else if (i_tx_done) begin
                if (sent == CNT_W'(`DBG_DUMP_BYTES - 1)) begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    seg         <= seg_nxt;
                    idx         <= idx_nxt;
                    sent        <= sent + 1'b1;
                    tx_q.strobe <= 1'b1;
                    tx_q.data   <= seg_byte(snap, seg_nxt, idx_nxt);
                end
            end
        end
    end

    assign o_tx        = tx_q;
    assign o_dump_done = done_q;

endmodule

// File: hdl/debug_unit_top.sv
`timescale 1ns/1ns

module debug_unit_top (
    input  logic                           clk,
    input  logic                           i_rst_n,
    input  debug_dump_pkg::uart_byte_t     i_rx,
    input  logic                           i_tx_done,
    input  logic                           i_end,
    input  debug_dump_pkg::pipe_snapshot_t i_snapshot,
    output debug_dump_pkg::uart_byte_t     o_tx,
    output debug_cmd_pkg::instr_write_t    o_instr_wr,
    output logic                           o_step,
    output logic                           o_start
);

    logic load_en;          // Loader owns the received bytes
    logic load_halt;
    logic dump_start;
    logic dump_done;

    debug_ctrl u_ctrl (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_rx         (i_rx),
        .i_end        (i_end),
        .i_load_halt  (load_halt),
        .i_dump_done  (dump_done),
        .o_load_en    (load_en),
        .o_dump_start (dump_start),
        .o_step       (o_step),
        .o_start      (o_start)
    );

    instr_loader u_loader (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_rx        (i_rx),
        .i_load_en   (load_en),
        .o_instr_wr  (o_instr_wr),
        .o_load_halt (load_halt)
    );

    latch_dumper u_dumper (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_snapshot   (i_snapshot),
        .i_dump_start (dump_start),
        .i_tx_done    (i_tx_done),
        .o_tx         (o_tx),
        .o_dump_done  (dump_done)
    );

endmodule

// File: testbench/debug_unit_chk.sv
`timescale 1ns/1ns

module debug_unit_chk (
    input logic                         clk,
    input logic                         i_rst_n,
    input logic                         i_tx_done,
    input debug_dump_pkg::uart_byte_t   i_tx,
    input debug_cmd_pkg::instr_write_t  i_instr_wr,
    input logic                         i_step,
    input logic                         i_start
);

    int unsigned err_cnt = 0;   // Failed assertions so far
    logic        tx_waiting;    // Byte started, i_tx_done not yet seen

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tx_waiting <= 1'b0;
        end else if (i_tx.strobe) begin
            tx_waiting <= 1'b1;
        end else if (i_tx_done) begin
            tx_waiting <= 1'b0;
        end
    end

    tx_after_done: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_tx.strobe |-> !tx_waiting)
        else begin
            $error("Transmit strobe issued before i_tx_done of the previous byte");
            err_cnt++;
        end

    tx_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_tx.strobe |=> !i_tx.strobe)
        else begin
            $error("Transmit strobe longer than one cycle");
            err_cnt++;
        end

    wr_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_instr_wr.valid |=> !i_instr_wr.valid)
        else begin
            $error("Instruction write valid longer than one cycle");
            err_cnt++;
        end

    step_needs_start: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_step |-> i_start)
        else begin
            $error("o_step high while o_start is low");
            err_cnt++;
        end

endmodule

bind debug_unit_top debug_unit_chk u_chk (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_tx_done  (i_tx_done),
    .i_tx       (o_tx),
    .i_instr_wr (o_instr_wr),
    .i_step     (o_step),
    .i_start    (o_start)
);

// File: testbench/debug_unit_tb.sv
`timescale 1ns/1ns
`include "debug_settings.svh"

module debug_unit_tb;

    import debug_cmd_pkg::*;
    import debug_dump_pkg::*;

    localparam int TIMEOUT_CYCLES = 20000;  // Seven dumps of 30 bytes at 15 cycles, plus loading
    localparam int PROG_WORDS     = 5;      // Words before the halt word
    localparam int ID_EX_BYTES    = `DBG_ID_EX_W / `DBG_DATA_W;
    localparam int EX_MEM_BYTES   = `DBG_EX_MEM_W / `DBG_DATA_W;
    localparam int MEM_WB_BYTES   = `DBG_MEM_WB_W / `DBG_DATA_W;
    localparam logic [31:0] SEED  = 32'd33;

    logic           clk;
    logic           i_rst_n;
    uart_byte_t     i_rx;
    logic           i_tx_done;
    logic           i_end;
    pipe_snapshot_t i_snapshot;
    uart_byte_t     o_tx;
    instr_write_t   o_instr_wr;
    logic           o_step;
    logic           o_start;

    instr_write_t   exp_wr_q[$];
    uart_byte_t     exp_tx_q[$];
    logic [31:0]    snap_rng  = SEED;
    logic [31:0]    delay_rng = SEED;
    int unsigned    step_cnt  = 0;      // Cycles with o_step high
    int unsigned    tx_cnt    = 0;      // Transmit strobes seen
    int unsigned    cycle_cnt = 0;
    int unsigned    delay;
    logic           tx_busy;

    debug_unit_top u_dut (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_rx       (i_rx),
        .i_tx_done  (i_tx_done),
        .i_end      (i_end),
        .i_snapshot (i_snapshot),
        .o_tx       (o_tx),
        .o_instr_wr (o_instr_wr),
        .o_step     (o_step),
        .o_start    (o_start)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] program_word(input int n);
        if (n == PROG_WORDS) begin
            return `DBG_HALT_WORD;
        end
        return 32'h1357_9BDF + 32'(n) * 32'h0101_0101;
    endfunction

    // Write n lands at address 4n
    function automatic instr_write_t expected_write(input int n);
        instr_write_t w;
        w.valid = 1'b1;
        w.addr  = 32'(n * `DBG_ADDR_STEP);
        w.word  = program_word(n);
        return w;
    endfunction

    // Dump byte k in the order ID/EX, EX/MEM, MEM/WB and control, each low byte first
    function automatic logic [7:0] expected_dump_byte(input pipe_snapshot_t s, input int k);
        int j;
        j = k;
        if (j < ID_EX_BYTES) begin
            return s.id_ex[j*8 +: 8];
        end
        j = j - ID_EX_BYTES;
        if (j < EX_MEM_BYTES) begin
            return s.ex_mem[j*8 +: 8];
        end
        j = j - EX_MEM_BYTES;
        if (j < MEM_WB_BYTES) begin
            return s.mem_wb[j*8 +: 8];
        end
        j = j - MEM_WB_BYTES;
        return s.control[j*8 +: 8];
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_write(input instr_write_t exp, input instr_write_t act);
        if (act !== exp) begin
            report_error($sformatf("FAIL at %0t ns: o_instr_wr expected %h_%h_%h got %h_%h_%h",
                $time, exp.valid, exp.addr, exp.word, act.valid, act.addr, act.word));
        end
    endtask

    task automatic check_byte(input uart_byte_t exp, input uart_byte_t act);
        if (act !== exp) begin
            report_error($sformatf("FAIL at %0t ns: o_tx expected %b_%h got %b_%h",
                $time, exp.strobe, exp.data, act.strobe, act.data));
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_error($sformatf("FAIL at %0t ns: %s expected %b got %b",
                $time, name, exp, act));
        end
    endtask

    // Compares outputs at the falling edge where they are stable
    always @(negedge clk) begin
        if (u_dut.u_chk.err_cnt != 0) begin
            report_error("A bound assertion on the DUT ports failed");
        end
        if (o_step) begin
            step_cnt++;
        end
        if (o_instr_wr.valid) begin
            if (exp_wr_q.size() == 0) begin
                report_error("An instruction write came that was not expected");
            end else begin
                check_write(exp_wr_q.pop_front(), o_instr_wr);
            end
        end
        if (o_tx.strobe) begin
            tx_cnt++;
            if (exp_tx_q.size() == 0) begin
                report_error("A transmit byte came that was not expected");
            end else begin
                check_byte(exp_tx_q.pop_front(), o_tx);
            end
        end
    end

    // UART transmitter model with random busy time
    initial begin
        i_tx_done = 1'b0;
        tx_busy   = 1'b0;
        forever begin
            @(negedge clk);
            if (o_tx.strobe) begin
                tx_busy   = 1'b1;
                delay_rng = xorshift32(delay_rng);
                delay     = 1 + delay_rng % 12;
                repeat (delay) @(posedge clk);
                #1 i_tx_done = 1'b1;
                @(posedge clk);
                #1 i_tx_done = 1'b0;
                tx_busy = 1'b0;
            end
        end
    end

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        report_error("Timeout: the test did not finish within the cycle limit");
    end

    task automatic send_byte(input logic [7:0] b);
        @(posedge clk);
        #1 i_rx = '{strobe: 1'b1, data: b};
        @(posedge clk);
        #1 i_rx.strobe = 1'b0;
        repeat (3) @(posedge clk);          // Gap between bytes
    endtask

    task automatic new_snapshot();
        logic [255:0] bits;
        for (int i = 0; i < 8; i++) begin
            snap_rng = xorshift32(snap_rng);
            bits[i*32 +: 32] = snap_rng;
        end
        @(posedge clk);
        #1 i_snapshot = pipe_snapshot_t'(bits[$bits(pipe_snapshot_t)-1:0]);
    endtask

    task automatic queue_dump();
        uart_byte_t b;
        for (int k = 0; k < `DBG_DUMP_BYTES; k++) begin
            b.strobe = 1'b1;
            b.data   = expected_dump_byte(i_snapshot, k);
            exp_tx_q.push_back(b);
        end
    endtask

    task automatic wait_dump_end();
        while (exp_tx_q.size() != 0 || tx_busy) @(posedge clk);
        repeat (3) @(posedge clk);          // Room for dump_done and the mode update
    endtask

    task automatic dump_and_check(input logic [7:0] cmd, input int unsigned exp_steps);
        int unsigned step_base;
        new_snapshot();
        queue_dump();
        step_base = step_cnt;
        send_byte(cmd);
        wait_dump_end();
        if (step_cnt - step_base != exp_steps) begin
            report_error($sformatf("Command %h gave %0d step cycles instead of %0d",
                cmd, step_cnt - step_base, exp_steps));
        end
    endtask

    initial begin
        int unsigned step_base;
        int unsigned tx_base;
        logic [31:0] prog_word;

        i_rst_n    = 1'b0;
        i_rx       = '0;
        i_end      = 1'b0;
        i_snapshot = '0;
        repeat (10) @(posedge clk);
        #1 i_rst_n = 1'b1;

        // Reset and load
        @(negedge clk);
        check_write('0, o_instr_wr);
        check_byte('0, o_tx);
        check_level("o_step", 1'b0, o_step);
        check_level("o_start", 1'b0, o_start);
        for (int n = 0; n <= PROG_WORDS; n++) begin
            exp_wr_q.push_back(expected_write(n));
        end
        send_byte(CMD_LOAD);
        for (int n = 0; n <= PROG_WORDS; n++) begin
            prog_word = program_word(n);
            for (int b = 3; b >= 0; b--) begin
                send_byte(prog_word[b*8 +: 8]);         // Most significant byte first
            end
        end
        while (exp_wr_q.size() != 0) @(posedge clk);
        while (o_start) @(negedge clk);

        // Continuous run
        new_snapshot();
        send_byte(CMD_RUN);
        while (!o_step) @(negedge clk);
        repeat (8) begin
            @(negedge clk);
            check_level("o_step", 1'b1, o_step);
        end
        queue_dump();
        @(posedge clk);
        #1 i_end = 1'b1;
        while (exp_tx_q.size() != 0 || tx_busy) @(posedge clk);
        while (o_start) @(negedge clk);
        check_level("o_step", 1'b0, o_step);
        @(posedge clk);
        #1 i_end = 1'b0;

        // An unknown byte in debug mode does nothing
        send_byte(CMD_DEBUG);
        step_base = step_cnt;
        tx_base   = tx_cnt;
        send_byte(8'h55);
        repeat (8) @(posedge clk);
        if (step_cnt != step_base || tx_cnt != tx_base) begin
            report_error("An unknown byte in debug mode caused a step or a transmit");
        end
        dump_and_check(CMD_STEP, 1);
        @(negedge clk);
        check_level("o_start", 1'b1, o_start);

        // End of debug with a fresh snapshot
        dump_and_check(CMD_END_DEBUG, 0);
        while (o_start) @(negedge clk);

        // Several dumps back to back under random transmitter delays
        send_byte(CMD_DEBUG);
        repeat (3) dump_and_check(CMD_STEP, 1);
        dump_and_check(CMD_END_DEBUG, 0);
        while (o_start) @(negedge clk);

        if (u_dut.u_chk.err_cnt != 0) begin
            report_error($sformatf("%0d assertion failures were reported",
                u_dut.u_chk.err_cnt));
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

// File: sources.f
+incdir+include
hdl/debug_cmd_pkg.sv
hdl/debug_dump_pkg.sv
hdl/debug_ctrl.sv
hdl/instr_loader.sv
hdl/latch_dumper.sv
hdl/debug_unit_top.sv
testbench/debug_unit_chk.sv
testbench/debug_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the debug unit testbench with Verilator

rm -f sim.log

verilator --binary --assert -Wno-fatal -f sources.f --top-module debug_unit_tb \
    -o Vdebug_unit_tb > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/Vdebug_unit_tb +verilator+error+limit+100 > sim.log 2>&1

grep -q "Simulation failed" sim.log && { echo "FAILED, see sim.log"; exit 1; }
grep -q "Simulation passed" sim.log || { echo "No result, see sim.log"; exit 1; }
echo "PASSED"
exit 0
